// ==== Bender.yml ====
package:
  name: frame_checksum

sources:
  - logic/stream_pkg.sv
  - logic/fifo_pkg.sv
  - logic/simple_dual_port_ram.sv
  - logic/beat_tagger.sv
  - logic/fifo.sv
  - logic/frame_summer.sv
  - logic/frame_checksum_top.sv
  - target: simulation
    files:
      - verification/frame_checksum_assertions.sv
      - verification/frame_checksum_tb.sv

// ==== logic/beat_tagger.sv ====
`timescale 1ns/10ps

module beat_tagger (
  input  logic                         clk,
  input  logic                         rst,

  input  logic [stream_pkg::BYTE_W-1:0] in_byte,
  input  logic                         in_last,
  input  logic                         in_valid,
  output logic                         in_ready,

  output stream_pkg::beat_t            beat,
  output logic                         beat_valid,
  input  logic                         beat_ready
);

  // Held low through reset, opens the input one cycle after release
  logic                         rdy_en;
  logic [stream_pkg::IDX_W-1:0] idx_q;
  logic                         take;

  // Register empty or being drained this cycle
  assign in_ready = rdy_en && (!beat_valid || beat_ready);
  assign take     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_en     <= 1'b0;
      beat_valid <= 1'b0;
      idx_q      <= '0;
    end else begin
      rdy_en <= 1'b1;

      if (take) begin
        beat_valid <= 1'b1;
      end else if (beat_ready) begin
        beat_valid <= 1'b0;
      end

      // Next frame starts counting from zero
      if (take) begin
        idx_q <= in_last ? '0 : idx_q + 1'b1;
      end
    end
  end

  // Payload only moves on an accepted byte
  always_ff @(posedge clk) begin
    if (take) begin
      beat <= '{data: in_byte, idx: idx_q, last: in_last};
    end
  end

endmodule

// ==== logic/fifo.sv ====
`timescale 1ns/10ps

module fifo (
  input  logic              clk,
  input  logic              rst,

  input  stream_pkg::beat_t in_data,
  input  logic              in_valid,
  output logic              in_ready,

  output stream_pkg::beat_t out_data,
  output logic              out_valid,
  input  logic              out_ready,

  output logic              empty,
  output logic              full
);

  typedef struct packed {
    // Write side
    logic [fifo_pkg::PTR_W-1:0] wr_ptr;
    logic [fifo_pkg::PTR_W-1:0] size;
    // Read side
    logic [fifo_pkg::PTR_W-1:0] rd_ptr;
    logic                       rd_issued;
    // Which register currently feeds the output
    logic                       sel_extra;
    logic                       out_vld;
    logic                       extra_vld;
  } ctrl_t;

  ctrl_t             ctrl_q;
  ctrl_t             ctrl_d;

  // Output register and the spill register for a read still in flight
  stream_pkg::beat_t out_q;
  stream_pkg::beat_t out_d;
  stream_pkg::beat_t extra_q;
  stream_pkg::beat_t extra_d;

  logic              ram_wr_en;
  logic              rd_en;
  logic              pause_reads;
  stream_pkg::beat_t ram_rd_dout;

  always_comb begin
    ctrl_d  = ctrl_q;
    out_d   = out_q;
    extra_d = extra_q;

    in_ready = ctrl_q.size != fifo_pkg::DEPTH - 1;

    // No transfer this cycle and something already waiting at the output
    pause_reads = !out_ready && (ctrl_q.out_vld || ctrl_q.extra_vld);

    // Write side
    ram_wr_en = in_valid && in_ready;
    if (ram_wr_en) begin
      if (ctrl_q.wr_ptr == fifo_pkg::DEPTH - 1) begin
        ctrl_d.wr_ptr = '0;
      end else begin
        ctrl_d.wr_ptr = ctrl_q.wr_ptr + 1'b1;
      end
      ctrl_d.size = ctrl_d.size + 1'b1;
    end

    // Read side
    rd_en = (ctrl_q.size != 0) && !pause_reads;
    if (rd_en) begin
      if (ctrl_q.rd_ptr == fifo_pkg::DEPTH - 1) begin
        ctrl_d.rd_ptr = '0;
      end else begin
        ctrl_d.rd_ptr = ctrl_q.rd_ptr + 1'b1;
      end
      ctrl_d.size = ctrl_d.size - 1'b1;
    end
    ctrl_d.rd_issued = rd_en;

    // RAM data lands in the spill register when the output is stuck
    if (ctrl_q.rd_issued) begin
      if (ctrl_q.out_vld && !out_ready) begin
        extra_d          = ram_rd_dout;
        ctrl_d.extra_vld = 1'b1;
      end else begin
        out_d          = ram_rd_dout;
        ctrl_d.out_vld = 1'b1;
      end
    end

    // Output select
    if (ctrl_q.sel_extra) begin
      out_data  = extra_q;
      out_valid = ctrl_q.extra_vld;
      if (out_ready && ctrl_q.extra_vld) begin
        ctrl_d.extra_vld = 1'b0;
        ctrl_d.sel_extra = 1'b0;
      end
    end else begin
      out_data  = out_q;
      out_valid = ctrl_q.out_vld;
      if (out_ready && ctrl_q.out_vld) begin
        ctrl_d.out_vld = ctrl_q.rd_issued;
        // Spilled beat is older than anything arriving now
        if (ctrl_q.extra_vld) begin
          ctrl_d.sel_extra = 1'b1;
        end
      end
    end
  end

  simple_dual_port_ram ram_i (
    .clk     (clk),
    .wr_addr (ctrl_q.wr_ptr[fifo_pkg::ADDR_W-1:0]),
    .wr_din  (in_data),
    .wr_en   (ram_wr_en),
    .rd_addr (ctrl_q.rd_ptr[fifo_pkg::ADDR_W-1:0]),
    .rd_dout (ram_rd_dout)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl_d;
    end
  end

  always_ff @(posedge clk) begin
    out_q   <= out_d;
    extra_q <= extra_d;
  end

  assign empty = ctrl_q.size == 0;
  // Same point at which the input closes
  assign full  = ctrl_q.size == fifo_pkg::DEPTH - 1;

endmodule

// ==== logic/fifo_pkg.sv ====
package fifo_pkg;

  // Number of RAM entries behind the FIFO
  localparam int DEPTH = 16;

  // RAM address width, kept at one bit for a single-entry RAM
  localparam int ADDR_W = (DEPTH == 1) ? 1 : $clog2(DEPTH);

  // Pointers and occupancy counter need one bit more than the address
  localparam int PTR_W = ADDR_W + 1;

endpackage

// ==== logic/frame_checksum_top.sv ====
`timescale 1ns/10ps

module frame_checksum_top (
  input  logic                          clk,
  input  logic                          rst,

  input  logic [stream_pkg::BYTE_W-1:0] in_byte,
  input  logic                          in_last,
  input  logic                          in_valid,
  output logic                          in_ready,

  output stream_pkg::result_t           res,
  output logic                          res_valid,
  input  logic                          res_ready,

  output logic                          empty,
  output logic                          full
);

  // Tagger to FIFO
  stream_pkg::beat_t tag_beat;
  logic              tag_valid;
  logic              tag_ready;

  // FIFO to summer
  stream_pkg::beat_t buf_beat;
  logic              buf_valid;
  logic              buf_ready;

  beat_tagger tagger_i (
    .clk        (clk),
    .rst        (rst),
    .in_byte    (in_byte),
    .in_last    (in_last),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .beat       (tag_beat),
    .beat_valid (tag_valid),
    .beat_ready (tag_ready)
  );

  fifo fifo_i (
    .clk       (clk),
    .rst       (rst),
    .in_data   (tag_beat),
    .in_valid  (tag_valid),
    .in_ready  (tag_ready),
    .out_data  (buf_beat),
    .out_valid (buf_valid),
    .out_ready (buf_ready),
    .empty     (empty),
    .full      (full)
  );

  frame_summer summer_i (
    .clk        (clk),
    .rst        (rst),
    .beat       (buf_beat),
    .beat_valid (buf_valid),
    .beat_ready (buf_ready),
    .res        (res),
    .res_valid  (res_valid),
    .res_ready  (res_ready)
  );

endmodule

// ==== logic/frame_summer.sv ====
`timescale 1ns/10ps

module frame_summer (
  input  logic                clk,
  input  logic                rst,

  input  stream_pkg::beat_t   beat,
  input  logic                beat_valid,
  output logic                beat_ready,

  output stream_pkg::result_t res,
  output logic                res_valid,
  input  logic                res_ready
);

  logic [stream_pkg::SUM_W-1:0] sum_q;
  logic [stream_pkg::IDX_W-1:0] cnt_q;
  logic [stream_pkg::SUM_W-1:0] sum_next;
  logic [stream_pkg::IDX_W-1:0] len_next;
  logic                         take;

  // Sticky, set when a tagged index disagrees with the local count
  logic                         idx_mismatch;

  // Stall the input while a finished result waits to be taken
  assign beat_ready = !res_valid || res_ready;
  assign take       = beat_valid && beat_ready;

  // Sum wraps modulo 65536 by width
  assign sum_next = sum_q +
                    {{(stream_pkg::SUM_W - stream_pkg::BYTE_W){1'b0}}, beat.data};
  assign len_next = cnt_q + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_q        <= '0;
      cnt_q        <= '0;
      res_valid    <= 1'b0;
      idx_mismatch <= 1'b0;
    end else begin
      if (take) begin
        if (beat.last) begin
          sum_q <= '0;
          cnt_q <= '0;
        end else begin
          sum_q <= sum_next;
          cnt_q <= len_next;
        end

        if (beat.idx != cnt_q) begin
          idx_mismatch <= 1'b1;
        end
      end

      if (take && beat.last) begin
        res_valid <= 1'b1;
      end else if (res_ready) begin
        res_valid <= 1'b0;
      end
    end
  end

  // Result payload, loaded on the last byte of each frame
  always_ff @(posedge clk) begin
    if (take && beat.last) begin
      res <= '{sum: sum_next, len: len_next};
    end
  end

endmodule

// ==== logic/simple_dual_port_ram.sv ====
`timescale 1ns/10ps

module simple_dual_port_ram (
  input  logic                        clk,

  input  logic [fifo_pkg::ADDR_W-1:0] wr_addr,
  input  stream_pkg::beat_t           wr_din,
  input  logic                        wr_en,

  input  logic [fifo_pkg::ADDR_W-1:0] rd_addr,
  output stream_pkg::beat_t           rd_dout
);

  stream_pkg::beat_t mem [fifo_pkg::DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_din;
    end
  end

  // Registered read, data shows up one cycle after the address
  always_ff @(posedge clk) begin
    rd_dout <= mem[rd_addr];
  end

endmodule

// ==== logic/stream_pkg.sv ====
package stream_pkg;

  // Byte lane on the input stream
  localparam int BYTE_W = 8;

  // Position of a byte inside its frame, wraps past 255
  localparam int IDX_W = 8;

  // Frame checksum, byte sum modulo 65536
  localparam int SUM_W = 16;

  // One tagged byte as it moves from tagger through FIFO to summer
  typedef struct packed {
    logic [BYTE_W-1:0] data;
    logic [IDX_W-1:0]  idx;
    logic              last;
  } beat_t;

  // One finished frame
  typedef struct packed {
    logic [SUM_W-1:0] sum;
    logic [IDX_W-1:0] len;
  } result_t;

endpackage

// ==== verification/frame_checksum_assertions.sv ====
`timescale 1ns/10ps

module frame_checksum_assertions (
  input logic                          clk,
  input logic                          rst,
  input logic [stream_pkg::BYTE_W-1:0] in_byte,
  input logic                          in_last,
  input logic                          in_valid,
  input logic                          in_ready,
  input stream_pkg::beat_t             tag_beat,
  input logic                          tag_valid,
  input logic                          tag_ready,
  input stream_pkg::beat_t             buf_beat,
  input logic                          buf_valid,
  input logic                          buf_ready,
  input stream_pkg::result_t           res,
  input logic                          res_valid,
  input logic                          res_ready,
  input logic                          empty,
  input logic                          full,
  input logic                          idx_mismatch
);

  // Number of failed checks so far
  int fail_count = 0;

  // Beats inside the FIFO, counted at its write and read handshakes
  logic [fifo_pkg::PTR_W:0] fifo_level;
  logic                     wr_beat;
  logic                     rd_beat;

  assign wr_beat = tag_valid && tag_ready;
  assign rd_beat = buf_valid && buf_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      fifo_level <= '0;
    end else if (wr_beat && !rd_beat) begin
      fifo_level <= fifo_level + 1'b1;
    end else if (rd_beat && !wr_beat) begin
      fifo_level <= fifo_level - 1'b1;
    end
  end

  function automatic void note_failure(input string what);
    fail_count++;
    $error("%0s", what);
  endfunction

  // Each source holds valid and payload until the transfer
  assert property (@(posedge clk) disable iff (rst)
    in_valid && !in_ready |=> in_valid && $stable({in_byte, in_last}))
    else note_failure("Input byte changed or dropped before it was accepted");

  assert property (@(posedge clk) disable iff (rst)
    tag_valid && !tag_ready |=> tag_valid && $stable(tag_beat))
    else note_failure("Tagger beat changed or dropped before the FIFO took it");

  assert property (@(posedge clk) disable iff (rst)
    buf_valid && !buf_ready |=> buf_valid && $stable(buf_beat))
    else note_failure("FIFO output changed or dropped before the summer took it");

  assert property (@(posedge clk) disable iff (rst)
    res_valid && !res_ready |=> res_valid && $stable(res))
    else note_failure("Result changed or dropped before it was taken");

  // RAM closes at DEPTH-1 entries and at most two beats sit behind it
  assert property (@(posedge clk) disable iff (rst)
    tag_ready |-> fifo_level <= fifo_pkg::DEPTH)
    else note_failure("FIFO open for writes while already holding a full load");

  assert property (@(posedge clk) disable iff (rst)
    full |-> fifo_level >= fifo_pkg::DEPTH - 1)
    else note_failure("FIFO reports full while holding fewer beats");

  // With the RAM empty, a valid output can only be a beat written earlier
  assert property (@(posedge clk) disable iff (rst)
    empty && buf_valid |-> fifo_level != 0)
    else note_failure("FIFO shows valid output with no beat stored");

  assert property (@(posedge clk) disable iff (rst) !idx_mismatch)
    else note_failure("Beat index disagrees with the summer's byte count");

endmodule

bind frame_checksum_top frame_checksum_assertions asrt_i (
  .*,
  .idx_mismatch (summer_i.idx_mismatch)
);

// ==== verification/frame_checksum_tb.sv ====
`timescale 1ns/10ps

module frame_checksum_tb;

  logic                          clk;
  logic                          rst;
  logic [stream_pkg::BYTE_W-1:0] in_byte;
  logic                          in_last;
  logic                          in_valid;
  logic                          in_ready;
  stream_pkg::result_t           res;
  logic                          res_valid;
  logic                          res_ready;
  logic                          empty;
  logic                          full;

  // One entry per line of the tests file
  reg [8*16-1:0] names [0:31];
  integer        nbytes [0:31];
  integer        offs [0:31];
  integer        stall [0:31];
  integer        exp_sum [0:31];
  integer        exp_len [0:31];
  integer        n_tests;
  integer        total_bytes;
  integer        cycles = 0;
  integer        cycle_limit;
  integer        stall_seed;
  integer        byte_seed;

  frame_checksum_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped on the first error");
  endtask

  task automatic check_value(input reg [8*16-1:0] name, input string what,
                             input integer expected, input integer actual);
    if (expected !== actual) begin
      $display("Mismatch in test %0s: %0s expected %0d, actual %0d",
               name, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic read_tests();
    integer         fd;
    integer         code;
    reg [8*16-1:0]  tok;
    reg [8*128-1:0] rest;
    n_tests     = 0;
    total_bytes = 0;
    fd = $fopen("verification/frame_checksum_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the tests file verification/frame_checksum_tests.txt");
      abort_run();
    end else begin
      code = $fscanf(fd, "%s", tok);
      while (code == 1) begin
        // Comment lines start with a lone hash
        if (tok == "#") begin
          code = $fgets(rest, fd);
        end else begin
          names[n_tests] = tok;
          code = $fscanf(fd, "%d %d %d %h %d", nbytes[n_tests], offs[n_tests],
                         stall[n_tests], exp_sum[n_tests], exp_len[n_tests]);
          total_bytes = total_bytes + nbytes[n_tests];
          n_tests     = n_tests + 1;
        end
        code = $fscanf(fd, "%s", tok);
      end
      $fclose(fd);
    end
  endtask

  task automatic send_byte(input logic [7:0] b, input logic last);
    logic taken;
    in_byte  = b;
    in_last  = last;
    in_valid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
      #2;
    end
  endtask

  task automatic drive_frames();
    integer     t;
    integer     i;
    integer     r;
    integer     sum;
    logic [7:0] b;
    for (t = 0; t < n_tests; t++) begin
      byte_seed = 32'h4b4b_a397 + offs[t];
      sum = 0;
      for (i = 0; i < nbytes[t]; i++) begin
        if ((nbytes[t] % 2 == 1) && (i == nbytes[t] - 1)) begin
          b = offs[t][7:0];
        end else if (i % 2 == 0) begin
          r = $random(byte_seed);
          b = r[7:0];
        end else begin
          // Partner byte, each pair adds up to 255
          b = ~b;
        end
        sum = (sum + b) % 65536;
        send_byte(b, i == nbytes[t] - 1);
      end
      check_value(names[t], "file sum", exp_sum[t], sum);
      check_value(names[t], "file length", exp_len[t], nbytes[t]);
    end
    in_valid = 1'b0;
  endtask

  task automatic collect_results();
    integer              t;
    integer              pct;
    logic                got;
    stream_pkg::result_t r;
    for (t = 0; t < n_tests; t++) begin
      pct = stall[t];
      if (stall[t] == 100) begin
        // Hold the result back until the input path has backed up
        res_ready = 1'b0;
        got = 1'b0;
        while (!got) begin
          @(negedge clk);
          got = full && !in_ready;
          @(posedge clk);
          #2;
        end
        pct = 0;
      end
      got = 1'b0;
      while (!got) begin
        res_ready = ({$random(stall_seed)} % 100) >= pct;
        @(negedge clk);
        got = res_valid && res_ready;
        r   = res;
        @(posedge clk);
        #2;
      end
      check_value(names[t], "sum", exp_sum[t], r.sum);
      check_value(names[t], "length", exp_len[t], r.len);
    end
    res_ready = 1'b0;
  endtask

  always @(negedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Run exceeded its cycle limit of %0d cycles", cycle_limit);
      abort_run();
    end else if (dut_i.asrt_i.fail_count != 0) begin
      $display("A handshake or FIFO assertion failed");
      abort_run();
    end
  end

  initial begin
    rst        = 1'b1;
    in_byte    = '0;
    in_last    = 1'b0;
    in_valid   = 1'b0;
    res_ready  = 1'b0;
    stall_seed = 32'h4b4b_a397;
    read_tests();
    cycle_limit = 40 * total_bytes + 200;

    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;

    // Idle state before the first byte, input opens one cycle later
    check_value("reset", "res_valid", 0, res_valid);
    check_value("reset", "empty", 1, empty);
    check_value("reset", "full", 0, full);
    check_value("reset", "in_ready", 0, in_ready);

    fork
      drive_frames();
      collect_results();
    join

    // All results taken, so the buffer drains and the input reopens
    while (!empty) begin
      @(negedge clk);
    end
    check_value("drain", "in_ready", 1, in_ready);

    if (dut_i.asrt_i.fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("A handshake or FIFO assertion failed");
      abort_run();
    end
  end

endmodule

// ==== verification/frame_checksum_tests.txt ====
# name  bytes  seed_offset  stall_pct  sum_hex  length
# bytes come in random complement pairs and an odd frame ends with the offset low byte
single       1    17   0    0011  1
short_three  3    32   0    011F  3
short_four   4    5    0    01FE  4
b2b_one      1    1    0    0001  1
b2b_two      1    2    0    0002  1
b2b_three    1    3    0    0003  1
b2b_pair     2    7    0    00FF  2
hold_full    3    64   100  013F  3
long200      200  51   0    639C  200
stall_a      10   9    70   04FB  10
stall_b      7    10   70   0307  7
stall_c      1    254  70   00FE  1
stall_d      33   129  70   1071  33
max255       255  255  50   7F80  255
tail         2    3    0    00FF  2

// ==== verilog.f ====
logic/stream_pkg.sv
logic/fifo_pkg.sv
logic/simple_dual_port_ram.sv
logic/beat_tagger.sv
logic/fifo.sv
logic/frame_summer.sv
logic/frame_checksum_top.sv
verification/frame_checksum_assertions.sv
verification/frame_checksum_tb.sv
